/* design/byteRam.sv */
`timescale 1ns/100ps

module byteRam #(
    parameter int ramAddrBits = 12
) (
    input  logic             clk,
    input  memBusPkg::addr_t addr,
    input  logic             write,
    input  memBusPkg::byte_t wdata,
    output memBusPkg::byte_t rdata
);

    localparam int depth = 2 ** ramAddrBits;

    memBusPkg::byte_t mem [depth];

    logic [ramAddrBits-1:0] index;

    // upper address bits wrap onto the array
    assign index = addr[ramAddrBits-1:0];

    // read returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        if (write) begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

endmodule

/* design/memBusPkg.sv */
package memBusPkg;

    // CPU side bus widths
    localparam int addrBits = 32;
    localparam int wordBits = 32;

    // RAM side is one byte wide
    localparam int byteBits = 8;

    // bytes per word, also the size of every fetch
    localparam int wordBytes = 4;

    // length field must hold the value 4
    localparam int lenBits = 3;

    // byte position inside a word
    localparam int idxBits = $clog2(wordBytes);

    typedef logic [addrBits-1:0] addr_t;

    typedef logic [byteBits-1:0] byte_t;

    typedef logic [wordBits-1:0] word_t;

    // legal values 1, 2 and 4
    typedef logic [lenBits-1:0] len_t;

    typedef logic [idxBits-1:0] byteIdx_t;

endpackage

/* design/memByteSequencer.sv */
`timescale 1ns/100ps

module memByteSequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  start,
    input  memCtrlPkg::access_t   access,
    output logic                  busy,
    output memBusPkg::addr_t      memAddr,
    output logic                  memWrite,
    output memBusPkg::byte_t      memWdata,
    output memCtrlPkg::byteBeat_t beat
);

    memCtrlPkg::seqState_e state;
    memBusPkg::byteIdx_t   idx;
    memBusPkg::byteIdx_t   addrIdx;
    logic                  isLast;
    logic                  isWrite;

    assign isWrite = (access.kind == memCtrlPkg::dataWrite);

    assign isLast = (memBusPkg::len_t'(idx) + memBusPkg::len_t'(1)) == access.len;

    // busy covers run and the cycle that hands over the last beat
    assign busy = (state != memCtrlPkg::seqIdle);

    // while stalled the RAM points at the byte already in flight
    // so its read register keeps the value the assembler still needs
    assign addrIdx = stall ? beat.idx : idx;

    // little-endian so byte idx sits at base + idx
    assign memAddr = access.addr + memBusPkg::addr_t'(addrIdx);

    assign memWrite = !stall && (state == memCtrlPkg::seqRun) && isWrite;

    assign memWdata = access.wdata[memBusPkg::byteBits*idx +: memBusPkg::byteBits];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memCtrlPkg::seqIdle;
            idx   <= '0;
            beat  <= '0;
        end else if (!stall) begin
            case (state)
                memCtrlPkg::seqIdle: begin
                    beat <= '0;
                    if (start) begin
                        state <= memCtrlPkg::seqRun;
                        idx   <= '0;
                    end
                end
                memCtrlPkg::seqRun: begin
                    // beat lags the address by one cycle like the RAM read
                    beat.rdValid <= !isWrite;
                    beat.idx     <= idx;
                    beat.last    <= isLast;
                    beat.kind    <= access.kind;
                    if (isLast) begin
                        state <= memCtrlPkg::seqFinish;
                    end else begin
                        idx <= idx + memBusPkg::byteIdx_t'(1);
                    end
                end
                memCtrlPkg::seqFinish: begin
                    beat  <= '0;
                    state <= memCtrlPkg::seqIdle;
                end
                default: begin
                    beat  <= '0;
                    state <= memCtrlPkg::seqIdle;
                end
            endcase
        end
    end

    // strobe only on a settled access and never over a pending read beat
    writeInRun: assert property (@(posedge clk) disable iff (rst)
        memWrite |-> !beat.rdValid && $stable(access));

    // byte counter stays inside the access length
    idxInRange: assert property (@(posedge clk) disable iff (rst)
        state == memCtrlPkg::seqRun |-> memBusPkg::len_t'(idx) < access.len);

endmodule

/* design/memCtrlPkg.sv */
package memCtrlPkg;

    typedef enum logic [1:0] {
        instRead  = 2'd0,
        dataRead  = 2'd1,
        dataWrite = 2'd2
    } accessKind_e;

    typedef enum logic [1:0] {
        seqIdle   = 2'd0,
        seqRun    = 2'd1,
        seqFinish = 2'd2
    } seqState_e;

    // instruction fetch unit request, held until done
    typedef struct packed {
        logic             valid;
        memBusPkg::addr_t addr;
    } fetchReq_t;

    // data cache port request, store high for a write
    typedef struct packed {
        logic             valid;
        logic             store;
        memBusPkg::len_t  len;
        memBusPkg::addr_t addr;
        memBusPkg::word_t wdata;
    } dataReq_t;

    typedef struct packed {
        logic             done;
        memBusPkg::word_t inst;
    } fetchResp_t;

    typedef struct packed {
        logic             done;
        memBusPkg::word_t data;
    } dataResp_t;

    // winning request as latched by the arbiter
    typedef struct packed {
        accessKind_e      kind;
        memBusPkg::addr_t addr;
        memBusPkg::len_t  len;
        memBusPkg::word_t wdata;
    } access_t;

    // one marker per byte, aligned with the RAM read data
    typedef struct packed {
        logic               rdValid;
        memBusPkg::byteIdx_t idx;
        logic               last;
        accessKind_e        kind;
    } byteBeat_t;

endpackage

/* design/memReqArbiter.sv */
`timescale 1ns/100ps

module memReqArbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  busy,
    input  logic                  respDone,
    input  memCtrlPkg::fetchReq_t fetchReq,
    input  memCtrlPkg::dataReq_t  dataReq,
    output logic                  start,
    output memCtrlPkg::access_t   access,
    output logic                  fetchWait,
    output logic                  dataWait
);

    logic free;
    logic takeData;
    logic takeFetch;

    // wait flags stay up until the done is seen, so a held request is not taken twice
    assign free = !stall && !busy && !respDone && !fetchWait && !dataWait;

    // data port has priority
    assign takeData  = free && dataReq.valid;
    assign takeFetch = free && fetchReq.valid && !dataReq.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            start     <= 1'b0;
            fetchWait <= 1'b0;
            dataWait  <= 1'b0;
        end else if (!stall) begin
            start <= takeData || takeFetch;
            if (takeData) begin
                fetchWait <= 1'b1;
            end else if (respDone) begin
                fetchWait <= 1'b0;
            end
            if (takeFetch) begin
                dataWait <= 1'b1;
            end else if (respDone) begin
                dataWait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (takeData) begin
            access.kind  <= dataReq.store ? memCtrlPkg::dataWrite : memCtrlPkg::dataRead;
            access.addr  <= dataReq.addr;
            access.len   <= dataReq.len;
            access.wdata <= dataReq.wdata;
        end else if (takeFetch) begin
            access.kind  <= memCtrlPkg::instRead;
            access.addr  <= fetchReq.addr;
            // fetch is always a full word
            access.len   <= memBusPkg::len_t'(memBusPkg::wordBytes);
            access.wdata <= '0;
        end
    end

    // new access only once the sequencer has gone idle
    startWhileIdle: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

/* design/memRespAssembler.sv */
`timescale 1ns/100ps

module memRespAssembler (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  memCtrlPkg::byteBeat_t  beat,
    input  memBusPkg::byte_t       memRdata,
    output memCtrlPkg::fetchResp_t fetchResp,
    output memCtrlPkg::dataResp_t  dataResp,
    output logic                   respDone
);

    memBusPkg::word_t        word;
    logic                    readFinish;
    memCtrlPkg::accessKind_e readKind;
    logic                    fetchDone;
    logic                    dataDone;

    // byte zero clears the word, so short loads come out zero-extended
    always_ff @(posedge clk) begin
        if (!stall && beat.rdValid) begin
            if (beat.idx == '0) begin
                word <= memBusPkg::word_t'(memRdata);
            end else begin
                word[memBusPkg::byteBits*beat.idx +: memBusPkg::byteBits] <= memRdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readFinish <= 1'b0;
            readKind   <= memCtrlPkg::instRead;
            fetchDone  <= 1'b0;
            dataDone   <= 1'b0;
        end else if (!stall) begin
            // read done waits one cycle for the last byte to land in word
            readFinish <= beat.rdValid && beat.last;
            readKind   <= beat.kind;
            fetchDone  <= readFinish && (readKind == memCtrlPkg::instRead);
            dataDone   <= (readFinish && (readKind == memCtrlPkg::dataRead))
                       || (beat.last && (beat.kind == memCtrlPkg::dataWrite));
        end
    end

    // done registers hold through a stall, show them once it clears
    assign fetchResp.done = fetchDone && !stall;
    assign fetchResp.inst = word;
    assign dataResp.done  = dataDone && !stall;
    assign dataResp.data  = word;

    assign respDone = fetchResp.done || dataResp.done;

    // one client served at a time
    oneDoneAtATime: assert property (@(posedge clk) disable iff (rst)
        !(fetchResp.done && dataResp.done));

endmodule

/* design/memSubsystem.sv */
`timescale 1ns/100ps

module memSubsystem #(
    parameter int ramAddrBits = 12
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioBufferFull,
    input  memCtrlPkg::fetchReq_t  fetchReq,
    input  memCtrlPkg::dataReq_t   dataReq,
    output memCtrlPkg::fetchResp_t fetchResp,
    output memCtrlPkg::dataResp_t  dataResp,
    output logic                   fetchWait,
    output logic                   dataWait
);

    logic                  stall;
    logic                  start;
    logic                  busy;
    logic                  respDone;
    memCtrlPkg::access_t   access;
    memCtrlPkg::byteBeat_t beat;
    memBusPkg::addr_t      memAddr;
    logic                  memWrite;
    memBusPkg::byte_t      memWdata;
    memBusPkg::byte_t      memRdata;

    // freeze everything when the CPU is not ready or I/O is backed up
    assign stall = !rdy || ioBufferFull;

    memReqArbiter i_arbiter (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .busy      (busy),
        .respDone  (respDone),
        .fetchReq  (fetchReq),
        .dataReq   (dataReq),
        .start     (start),
        .access    (access),
        .fetchWait (fetchWait),
        .dataWait  (dataWait)
    );

    memByteSequencer i_sequencer (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .start    (start),
        .access   (access),
        .busy     (busy),
        .memAddr  (memAddr),
        .memWrite (memWrite),
        .memWdata (memWdata),
        .beat     (beat)
    );

    memRespAssembler i_assembler (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .beat      (beat),
        .memRdata  (memRdata),
        .fetchResp (fetchResp),
        .dataResp  (dataResp),
        .respDone  (respDone)
    );

    byteRam #(
        .ramAddrBits (ramAddrBits)
    ) i_ram (
        .clk   (clk),
        .addr  (memAddr),
        .write (memWrite),
        .wdata (memWdata),
        .rdata (memRdata)
    );

endmodule

/* dv/memSubsystemTb.sv */
`timescale 1ns/100ps

module memSubsystemTb;

    localparam int ramAddrBits = 12;
    localparam int timeoutCycles = 200;

    logic                   clk;
    logic                   rst;
    logic                   rdy;
    logic                   ioBufferFull;
    memCtrlPkg::fetchReq_t  fetchReq;
    memCtrlPkg::dataReq_t   dataReq;
    memCtrlPkg::fetchResp_t fetchResp;
    memCtrlPkg::dataResp_t  dataResp;
    logic                   fetchWait;
    logic                   dataWait;

    logic [31:0]      lfsr;
    memBusPkg::byte_t shadow [2**ramAddrBits];
    logic             stallOn;
    logic             dataIsLoad;
    memBusPkg::word_t expData;
    memBusPkg::word_t expInst;
    int               dataDones;
    int               fetchDones;
    int               dataIssued;
    int               fetchIssued;

    memSubsystem #(
        .ramAddrBits (ramAddrBits)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchReq     (fetchReq),
        .dataReq      (dataReq),
        .fetchResp    (fetchResp),
        .dataResp     (dataResp),
        .fetchWait    (fetchWait),
        .dataWait     (dataWait)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic memBusPkg::len_t pickLen();
        logic [31:0] r;
        r = randomBits(2);
        case (r[1:0])
            2'd0:    return 3'd1;
            2'd1:    return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    // little-endian word from the shadow bytes with upper bytes zero
    function automatic memBusPkg::word_t expectedRead(input memBusPkg::addr_t addr,
                                                      input memBusPkg::len_t len);
        memBusPkg::word_t w;
        memBusPkg::addr_t a;
        int               i;
        w = '0;
        for (i = 0; i < int'(len); i++) begin
            a = addr + memBusPkg::addr_t'(i);
            w[8*i +: 8] = shadow[a[ramAddrBits-1:0]];
        end
        return w;
    endfunction

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            reportFailure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
                                    name, actual, expected));
        end
    endtask

    // next drive point with a fresh stall pattern when enabled
    task automatic nextCycle();
        logic [31:0] r;
        @(posedge clk);
        #2;
        if (stallOn) begin
            r = randomBits(3);
            rdy = (r[1:0] != 2'b00);
            ioBufferFull = (r[2:1] == 2'b11);
        end else begin
            rdy = 1'b1;
            ioBufferFull = 1'b0;
        end
    endtask

    task automatic waitDone(input logic forFetch, input int expLatency);
        int   cycle;
        int   acceptAt;
        logic seen;
        logic otherWait;
        logic ownWait;
        logic done;
        cycle = 0;
        acceptAt = -1;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            otherWait = forFetch ? dataWait : fetchWait;
            ownWait = forFetch ? fetchWait : dataWait;
            done = forFetch ? fetchResp.done : dataResp.done;
            if (acceptAt < 0 && otherWait) begin
                acceptAt = cycle;
            end
            // the other client waits from accept through done
            if (acceptAt >= 0) begin
                checkValue(forFetch ? "dataWait" : "fetchWait", 32'(otherWait), 32'd1);
            end
            checkValue(forFetch ? "fetchWait" : "dataWait", 32'(ownWait), 32'd0);
            if (done) begin
                seen = 1'b1;
                if (acceptAt < 0) begin
                    reportFailure("done pulsed before the request was accepted");
                end
                if (expLatency >= 0) begin
                    checkValue("done latency", cycle - acceptAt, expLatency);
                end
            end else if (cycle == timeoutCycles) begin
                reportFailure(forFetch ? "timeout waiting for the fetch done"
                                       : "timeout waiting for the data done");
            end else begin
                cycle++;
                nextCycle();
            end
        end
    endtask

    task automatic runData(input logic store, input memBusPkg::addr_t addr,
                           input memBusPkg::len_t len, input memBusPkg::word_t wdata);
        int               lat;
        int               i;
        memBusPkg::addr_t a;
        lat = store ? int'(len) + 2 : int'(len) + 3;
        if (stallOn) begin
            lat = -1;
        end
        if (!store) begin
            expData = expectedRead(addr, len);
        end
        dataIsLoad = !store;
        dataReq.valid = 1'b1;
        dataReq.store = store;
        dataReq.len = len;
        dataReq.addr = addr;
        dataReq.wdata = wdata;
        dataIssued++;
        waitDone(1'b0, lat);
        if (store) begin
            for (i = 0; i < int'(len); i++) begin
                a = addr + memBusPkg::addr_t'(i);
                shadow[a[ramAddrBits-1:0]] = wdata[8*i +: 8];
            end
        end
        nextCycle();
        dataReq.valid = 1'b0;
        checkValue("data done count", dataDones, dataIssued);
    endtask

    task automatic runFetch(input memBusPkg::addr_t addr);
        expInst = expectedRead(addr, 3'd4);
        fetchReq.valid = 1'b1;
        fetchReq.addr = addr;
        fetchIssued++;
        waitDone(1'b1, stallOn ? -1 : memBusPkg::wordBytes + 3);
        nextCycle();
        fetchReq.valid = 1'b0;
        checkValue("fetch done count", fetchDones, fetchIssued);
    endtask

    // compares every response as its done is sampled
    always @(negedge clk) begin
        if (!rst) begin
            if ((!rdy || ioBufferFull) && (fetchResp.done || dataResp.done)) begin
                reportFailure("a done pulsed while the engine was stalled");
            end
            if (dataResp.done) begin
                dataDones++;
                if (dataIsLoad) begin
                    checkValue("dataResp.data", dataResp.data, expData);
                end
            end
            if (fetchResp.done) begin
                fetchDones++;
                checkValue("fetchResp.inst", fetchResp.inst, expInst);
            end
        end
    end

    initial begin
        memBusPkg::addr_t addr;
        memBusPkg::len_t  len;
        int               k;
        int               fetchBefore;
        lfsr = 32'h49fa_2172;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchReq = '0;
        dataReq = '0;
        stallOn = 1'b0;
        dataIsLoad = 1'b0;
        expData = '0;
        expInst = '0;
        dataDones = 0;
        fetchDones = 0;
        dataIssued = 0;
        fetchIssued = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // quiet outputs before the first request
        repeat (3) begin
            @(negedge clk);
            checkValue("done and wait flags",
                       {fetchResp.done, dataResp.done, fetchWait, dataWait}, 32'd0);
            nextCycle();
        end

        for (k = 0; k < 18; k++) begin
            len = (k % 3 == 0) ? 3'd1 : (k % 3 == 1) ? 3'd2 : 3'd4;
            addr = randomBits(32);
            runData(1'b1, addr, len, randomBits(32));
            runData(1'b0, addr, len, '0);
        end

        for (k = 0; k < 6; k++) begin
            addr = randomBits(32);
            runData(1'b1, addr, 3'd4, randomBits(32));
            runFetch(addr);
        end

        // data and fetch raised together and data wins
        addr = randomBits(32);
        runData(1'b1, addr, 3'd4, randomBits(32));
        expData = expectedRead(addr, 3'd2);
        expInst = expectedRead(addr, 3'd4);
        dataIsLoad = 1'b1;
        dataReq.valid = 1'b1;
        dataReq.store = 1'b0;
        dataReq.len = 3'd2;
        dataReq.addr = addr;
        fetchReq.valid = 1'b1;
        fetchReq.addr = addr;
        dataIssued++;
        fetchIssued++;
        fetchBefore = fetchDones;
        waitDone(1'b0, 5);
        nextCycle();
        dataReq.valid = 1'b0;
        checkValue("fetch done count", fetchDones, fetchBefore);
        waitDone(1'b1, 7);
        nextCycle();
        fetchReq.valid = 1'b0;
        checkValue("fetch done count", fetchDones, fetchIssued);

        stallOn = 1'b1;
        for (k = 0; k < 16; k++) begin
            addr = randomBits(32);
            len = pickLen();
            runData(1'b1, addr, len, randomBits(32));
            runData(1'b0, addr, len, '0);
            addr = randomBits(32);
            runData(1'b1, addr, 3'd4, randomBits(32));
            runFetch(addr);
        end
        stallOn = 1'b0;

        repeat (5) nextCycle();
        checkValue("data done count", dataDones, dataIssued);
        checkValue("fetch done count", fetchDones, fetchIssued);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* runSim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module memSubsystemTb \
    -Mdir obj_dir

./obj_dir/VmemSubsystemTb

/* sources.f */
design/memBusPkg.sv
design/memCtrlPkg.sv
design/byteRam.sv
design/memReqArbiter.sv
design/memByteSequencer.sv
design/memRespAssembler.sv
design/memSubsystem.sv
dv/memSubsystemTb.sv
